// File: build.f
hw/core_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/core_top.sv
verif/core_tb.sv

// File: hw/alu.sv
module alu (
  input  core_pkg::alu_op_e alu_op,
  input  core_pkg::data_t   a,
  input  core_pkg::data_t   b,
  input  core_pkg::shamt_t  shamt,
  output core_pkg::data_t   result
);

  import core_pkg::*;

  always_comb begin
    case (alu_op)
      ALU_ADD: begin
        result = a + b;
      end
      ALU_SUB: begin
        result = a - b;
      end
      ALU_AND: begin
        result = a & b;
      end
      ALU_OR: begin
        result = a | b;
      end
      ALU_XOR: begin
        result = a ^ b;
      end
      // unsigned compare
      ALU_SLT: begin
        result = (a < b) ? 32'd1 : 32'd0;
      end
      // shifts work on b only
      ALU_SLL: begin
        result = b << shamt;
      end
      ALU_SRL: begin
        result = b >> shamt;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: hw/core_pkg.sv
package core_pkg;

  ////////////////////////////////////////////////////////////
  // basic word types
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] data_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] imm_t;
  typedef logic [4:0]  shamt_t;

  localparam int NUM_REGS = 32;

  ////////////////////////////////////////////////////////////
  // instruction format
  ////////////////////////////////////////////////////////////

  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;
  localparam int SHAMT_MSB  = 10;
  localparam int SHAMT_LSB  = 6;
  // imm overlaps rd and shamt
  localparam int IMM_MSB    = 15;
  localparam int IMM_LSB    = 0;

  // undefined encodings decode like OP_NOP
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_XOR  = 6'd5,
    OP_SLT  = 6'd6,
    OP_SLL  = 6'd7,
    OP_SRL  = 6'd8,
    OP_ADDI = 6'd9,
    OP_ANDI = 6'd10,
    OP_ORI  = 6'd11
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////

  // decoded instruction held in id_ex
  typedef struct packed {
    logic     reg_write;
    alu_op_e  alu_op;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dst;
    logic     use_imm;
    imm_t     imm;
    shamt_t   shamt;
    data_t    opnd_a;
    data_t    opnd_b;
  } dec_uop_t;

  // one register write, also the ex_mem / mem_wb format
  typedef struct packed {
    logic     write;
    reg_idx_t dst;
    data_t    data;
  } wb_t;

endpackage

// File: hw/core_top.sv
module core_top (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             instr_valid,
  input  core_pkg::instr_t instr,
  output core_pkg::wb_t    wb
);

  import core_pkg::*;

  // regfile read ports, driven from if_id fields
  reg_idx_t rd_addr_a;
  reg_idx_t rd_addr_b;
  data_t    rd_data_a;
  data_t    rd_data_b;

  // id_ex contents
  dec_uop_t uop;

  decode_stage i_decode_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_addr_a   (rd_addr_a),
    .rd_addr_b   (rd_addr_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .uop         (uop)
  );

  register_file i_register_file (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wb        (wb)
  );

  // mem_wb feeds both the regfile and the port
  execute_stage i_execute_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .uop    (uop),
    .wb     (wb)
  );

endmodule

// File: hw/decode_stage.sv
module decode_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  core_pkg::instr_t   instr,
  output core_pkg::reg_idx_t rd_addr_a,
  output core_pkg::reg_idx_t rd_addr_b,
  input  core_pkg::data_t    rd_data_a,
  input  core_pkg::data_t    rd_data_b,
  output core_pkg::dec_uop_t uop
);

  import core_pkg::*;

  ////////////////////////////////////////////////////////////
  // if_id
  ////////////////////////////////////////////////////////////

  logic   if_id_valid;
  instr_t if_id_instr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_id_valid <= 1'b0;
    end else begin
      if_id_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if_id_instr <= instr;
  end

  ////////////////////////////////////////////////////////////
  // field slicing
  ////////////////////////////////////////////////////////////

  opcode_e  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  shamt_t   shamt;
  imm_t     imm;

  assign opcode = opcode_e'(if_id_instr[OPCODE_MSB:OPCODE_LSB]);
  assign rs     = if_id_instr[RS_MSB:RS_LSB];
  assign rt     = if_id_instr[RT_MSB:RT_LSB];
  assign rd     = if_id_instr[RD_MSB:RD_LSB];
  assign shamt  = if_id_instr[SHAMT_MSB:SHAMT_LSB];
  assign imm    = if_id_instr[IMM_MSB:IMM_LSB];

  assign rd_addr_a = rs;
  assign rd_addr_b = rt;

  ////////////////////////////////////////////////////////////
  // control table
  ////////////////////////////////////////////////////////////

  logic    ctl_write;
  alu_op_e ctl_alu_op;
  logic    ctl_use_imm;
  // high selects rd, low selects rt
  logic    ctl_reg_dst;

  always_comb begin
    ctl_write   = 1'b1;
    ctl_alu_op  = ALU_ADD;
    ctl_use_imm = 1'b0;
    ctl_reg_dst = 1'b1;
    case (opcode)
      OP_ADD: ctl_alu_op = ALU_ADD;
      OP_SUB: ctl_alu_op = ALU_SUB;
      OP_AND: ctl_alu_op = ALU_AND;
      OP_OR:  ctl_alu_op = ALU_OR;
      OP_XOR: ctl_alu_op = ALU_XOR;
      OP_SLT: ctl_alu_op = ALU_SLT;
      OP_SLL: ctl_alu_op = ALU_SLL;
      OP_SRL: ctl_alu_op = ALU_SRL;
      OP_ADDI: begin
        ctl_alu_op  = ALU_ADD;
        ctl_use_imm = 1'b1;
        ctl_reg_dst = 1'b0;
      end
      OP_ANDI: begin
        ctl_alu_op  = ALU_AND;
        ctl_use_imm = 1'b1;
        ctl_reg_dst = 1'b0;
      end
      OP_ORI: begin
        ctl_alu_op  = ALU_OR;
        ctl_use_imm = 1'b1;
        ctl_reg_dst = 1'b0;
      end
      // OP_NOP and undefined encodings
      default: ctl_write = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // id_ex
  ////////////////////////////////////////////////////////////

  dec_uop_t uop_d;

  always_comb begin
    uop_d.reg_write = if_id_valid & ctl_write;
    uop_d.alu_op    = ctl_alu_op;
    uop_d.rs        = rs;
    uop_d.rt        = rt;
    uop_d.dst       = ctl_reg_dst ? rd : rt;
    uop_d.use_imm   = ctl_use_imm;
    uop_d.imm       = imm;
    uop_d.shamt     = shamt;
    uop_d.opnd_a    = rd_data_a;
    uop_d.opnd_b    = rd_data_b;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uop <= '0;
    end else begin
      uop <= uop_d;
    end
  end

endmodule

// File: hw/execute_stage.sv
module execute_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  core_pkg::dec_uop_t uop,
  output core_pkg::wb_t      wb
);

  import core_pkg::*;

  wb_t ex_mem_q;
  wb_t mem_wb_q;

  ////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////

  // ex_mem is the younger producer, so it wins over mem_wb
  function automatic data_t fwd_operand(reg_idx_t idx, data_t rf_val);
    data_t val;
    val = rf_val;
    if (ex_mem_q.write && ex_mem_q.dst == idx) begin
      val = ex_mem_q.data;
    end else if (mem_wb_q.write && mem_wb_q.dst == idx) begin
      val = mem_wb_q.data;
    end
    return val;
  endfunction

  data_t fwd_a;
  data_t fwd_b;

  always_comb begin
    fwd_a = fwd_operand(uop.rs, uop.opnd_a);
  end

  always_comb begin
    fwd_b = fwd_operand(uop.rt, uop.opnd_b);
  end

  ////////////////////////////////////////////////////////////
  // operand select and alu
  ////////////////////////////////////////////////////////////

  data_t alu_b;
  data_t alu_result;

  // immediates are zero extended
  assign alu_b = uop.use_imm ? {16'h0000, uop.imm} : fwd_b;

  alu i_alu (
    .alu_op (uop.alu_op),
    .a      (fwd_a),
    .b      (alu_b),
    .shamt  (uop.shamt),
    .result (alu_result)
  );

  ////////////////////////////////////////////////////////////
  // ex_mem and mem_wb
  ////////////////////////////////////////////////////////////

  wb_t ex_mem_d;

  always_comb begin
    ex_mem_d.write = uop.reg_write;
    ex_mem_d.dst   = uop.dst;
    ex_mem_d.data  = alu_result;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem_q <= '0;
    end else begin
      ex_mem_q <= ex_mem_d;
    end
  end

  // mem stage is a plain delay, no data memory
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb_q <= '0;
    end else begin
      mem_wb_q <= ex_mem_q;
    end
  end

  assign wb = mem_wb_q;

endmodule

// File: hw/register_file.sv
module register_file (
  input  logic               clk,
  input  logic               arst_n,
  input  core_pkg::reg_idx_t rd_addr_a,
  input  core_pkg::reg_idx_t rd_addr_b,
  output core_pkg::data_t    rd_data_a,
  output core_pkg::data_t    rd_data_b,
  input  core_pkg::wb_t      wb
);

  import core_pkg::*;

  data_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.write) begin
      regs[wb.dst] <= wb.data;
    end
  end

  // write-first bypass
  // covers a producer three slots ahead of the reader
  function automatic data_t read_port(reg_idx_t addr);
    data_t val;
    val = regs[addr];
    if (wb.write && wb.dst == addr) begin
      val = wb.data;
    end
    return val;
  endfunction

  always_comb begin
    rd_data_a = read_port(rd_addr_a);
  end

  always_comb begin
    rd_data_b = read_port(rd_addr_b);
  end

endmodule

// File: verif/core_tb.sv
module core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  localparam int WB_LATENCY = 4;
  localparam int DRAIN_LIMIT = 40;

  logic   clk;
  logic   arst_n;
  logic   instr_valid;
  instr_t instr;
  wb_t    wb;

  core_top i_core_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb)
  );

  always #4 clk = ~clk;

  int          cycle;
  string       test_name;
  data_t       model_regs [NUM_REGS];
  wb_t         exp_wb [$];
  int          exp_cycle [$];
  string       exp_name [$];
  instr_t      prog [$];
  logic [31:0] lfsr_state;
  wb_t         cmp_wb;
  int          cmp_cycle;
  string       cmp_name;

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cycle <= 0;
    end else begin
      cycle <= cycle + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // error reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic fail_stop(string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wb_data(string name, data_t exp, data_t act);
    if (exp !== act) begin
      fail_stop($sformatf("FAIL %s wb.data expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_wb_reg(string name, reg_idx_t exp, reg_idx_t act);
    if (exp !== act) begin
      fail_stop($sformatf("FAIL %s wb.dst expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_latency(string name, int exp, int act);
    if (exp != act) begin
      fail_stop($sformatf("FAIL %s latency expected %0d actual %0d", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model and random source
  ////////////////////////////////////////////////////////////

  // architectural result of one instruction, in issue order
  function automatic wb_t ref_exec(instr_t i);
    logic [5:0] op;
    data_t      a;
    data_t      b;
    data_t      zimm;
    wb_t        r;
    op   = i[31:26];
    a    = model_regs[i[25:21]];
    b    = model_regs[i[20:16]];
    zimm = {16'h0000, i[15:0]};
    r.write = 1'b1;
    r.dst   = i[15:11];
    r.data  = '0;
    case (op)
      OP_ADD: r.data = a + b;
      OP_SUB: r.data = a - b;
      OP_AND: r.data = a & b;
      OP_OR:  r.data = a | b;
      OP_XOR: r.data = a ^ b;
      OP_SLT: r.data = (a < b) ? 32'd1 : 32'd0;
      OP_SLL: r.data = b << i[10:6];
      OP_SRL: r.data = b >> i[10:6];
      OP_ADDI, OP_ANDI, OP_ORI: begin
        r.dst = i[20:16];
        if (op == OP_ADDI) r.data = a + zimm;
        else if (op == OP_ANDI) r.data = a & zimm;
        else r.data = a | zimm;
      end
      default: r.write = 1'b0;
    endcase
    if (r.write) begin
      model_regs[r.dst] = r.data;
    end
    return r;
  endfunction

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'hD000_0001;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic instr_t enc_r(logic [5:0] op, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                   shamt_t sh);
    return {op, rs, rt, rd, sh, 6'b000000};
  endfunction

  function automatic instr_t enc_i(logic [5:0] op, reg_idx_t rs, reg_idx_t rt, imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  // opcodes 0..15 reach the undefined encodings, registers stay in r0..r7
  function automatic instr_t rand_instr();
    logic [3:0]  op;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [2:0]  rd;
    logic [10:0] low;
    op  = 4'(rand_bits(4));
    rs  = 3'(rand_bits(3));
    rt  = 3'(rand_bits(3));
    rd  = 3'(rand_bits(3));
    low = 11'(rand_bits(11));
    return {2'b00, op, 2'b00, rs, 2'b00, rt, 2'b00, rd, low};
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_slot(logic v, instr_t i);
    wb_t e;
    @(posedge clk);
    instr_valid <= v;
    instr <= i;
    if (v) begin
      e = ref_exec(i);
      if (e.write) begin
        exp_wb.push_back(e);
        // cycle still holds the count from before this edge
        exp_cycle.push_back(cycle + 1);
        exp_name.push_back(test_name);
      end
    end
  endtask

  task automatic random_slot();
    logic   v;
    instr_t i;
    v = (rand_bits(1) != 0);
    i = rand_instr();
    drive_slot(v, i);
  endtask

  task automatic idle(int n);
    repeat (n) drive_slot(1'b0, '0);
  endtask

  task automatic play(int gap);
    foreach (prog[k]) begin
      drive_slot(1'b1, prog[k]);
      idle(gap);
    end
    idle(1);
    prog.delete();
  endtask

  task automatic wait_drain(int limit);
    int n;
    n = 0;
    while (exp_wb.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_wb.size() != 0) begin
      fail_stop($sformatf("timeout in %s, writebacks never arrived", test_name));
    end
  endtask

  // every wb pulse must match the oldest outstanding writer
  always @(negedge clk) begin
    if (arst_n && wb.write) begin
      if (exp_wb.size() == 0) begin
        fail_stop($sformatf("unexpected writeback to r%0d in %s", wb.dst, test_name));
      end else begin
        cmp_wb    = exp_wb.pop_front();
        cmp_cycle = exp_cycle.pop_front();
        cmp_name  = exp_name.pop_front();
        check_wb_reg(cmp_name, cmp_wb.dst, wb.dst);
        check_wb_data(cmp_name, cmp_wb.data, wb.data);
        check_latency(cmp_name, WB_LATENCY, cycle - cmp_cycle);
      end
    end
  end

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr_state  = 32'd82;
    test_name   = "reset";
    foreach (model_regs[k]) model_regs[k] = '0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    test_name = "idle_after_reset";
    idle(20);

    // preload, then every opcode alone
    test_name = "single_op";
    prog = '{enc_i(OP_ORI, 0, 1, 16'hF0F3), enc_i(OP_ORI, 0, 2, 16'h00A5),
             enc_i(OP_ORI, 0, 3, 16'h8001), enc_r(OP_SLL, 0, 3, 4, 16),
             enc_r(OP_ADD, 1, 4, 5, 0), enc_r(OP_SUB, 2, 1, 6, 0),
             enc_r(OP_AND, 1, 2, 7, 0), enc_r(OP_OR, 1, 4, 8, 0),
             enc_r(OP_XOR, 2, 4, 9, 0), enc_r(OP_SLT, 4, 1, 10, 0),
             enc_r(OP_SLT, 1, 4, 11, 0), enc_r(OP_SLL, 0, 1, 12, 7),
             enc_r(OP_SRL, 0, 4, 13, 9), enc_i(OP_ADDI, 4, 14, 16'hFFFF),
             enc_i(OP_ANDI, 1, 15, 16'h8F0F), enc_i(OP_ORI, 4, 16, 16'h8000),
             enc_r(OP_NOP, 1, 2, 17, 0), enc_r(6'd45, 1, 2, 18, 0)};
    play(4);
    wait_drain(DRAIN_LIMIT);

    test_name = "b2b_chain";
    prog = '{enc_i(OP_ORI, 0, 20, 16'h1234), enc_r(OP_ADD, 20, 20, 21, 0),
             enc_r(OP_SUB, 21, 20, 22, 0), enc_r(OP_XOR, 22, 21, 20, 0),
             enc_i(OP_ANDI, 20, 23, 16'hFFF0), enc_r(OP_SLL, 0, 23, 24, 3),
             enc_r(OP_OR, 24, 1, 25, 0), enc_r(OP_SRL, 0, 25, 26, 2),
             enc_r(OP_SLT, 26, 25, 27, 0)};
    play(0);
    wait_drain(DRAIN_LIMIT);

    // distance 2 hits mem_wb, distance 3 hits the regfile bypass
    test_name = "distance_2_3";
    prog = '{enc_i(OP_ORI, 0, 28, 16'h0F0F), enc_r(OP_ADD, 1, 2, 29, 0),
             enc_r(OP_ADD, 28, 2, 30, 0), enc_i(OP_ORI, 0, 31, 16'h7777),
             enc_r(OP_NOP, 0, 0, 0, 0), enc_r(OP_XOR, 1, 2, 17, 0),
             enc_r(OP_SUB, 1, 31, 18, 0), enc_i(OP_ORI, 0, 19, 16'h00FF),
             enc_r(OP_AND, 2, 1, 20, 0), enc_r(OP_OR, 2, 19, 21, 0),
             enc_i(OP_ANDI, 1, 22, 16'h0FF0), enc_r(OP_SUB, 2, 1, 23, 0),
             enc_i(OP_ORI, 0, 24, 16'h0001), enc_r(OP_ADD, 22, 22, 25, 0)};
    play(0);
    wait_drain(DRAIN_LIMIT);

    // small register window for dense hazards
    test_name = "random_stream";
    repeat (400) begin
      random_slot();
    end
    idle(1);
    wait_drain(DRAIN_LIMIT);
    idle(10);

    $display("TB PASSED");
    $finish;
  end

endmodule
